// File: design/trigPkg.sv
`default_nettype none

package trigPkg;

  // One signed ADC sample
  typedef logic signed [11:0] sampleT;

  // One bit wider than a sample so it can exceed the full range
  typedef logic signed [12:0] thresholdT;

  // Accepted beats since reset
  typedef logic [47:0] timeStampT;

  localparam int laneCount = 4;

  // Four 16-bit lanes, each holding a sign-extended sample
  typedef logic [63:0] beatDataT;

  typedef struct packed {
    beatDataT  data;
    timeStampT stamp;
  } beatT;

  typedef logic [63:0] frameWordT;

  // First byte of the header and footer words
  localparam logic [7:0] headerMarker = 8'hA5;
  localparam logic [7:0] footerMarker = 8'h5A;

  typedef enum logic [1:0] {
    idle,
    header,
    data,
    footer
  } frameStateT;

endpackage

`default_nettype wire

// File: design/trigConfigRegs.sv
`timescale 1ns/100ps
`default_nettype none

module trigConfigRegs #(
  parameter int delayCntWidth = 5
) (
  input  wire                      sAxisAclk,
  input  wire                      rstN,
  input  wire [3:0]                paddr,
  input  wire                      psel,
  input  wire                      penable,
  input  wire                      pwrite,
  input  wire [31:0]               pwdata,
  output logic [31:0]              prdata,
  output logic                     pready,
  output logic                     pslverr,
  output trigPkg::thresholdT       threshold,
  output trigPkg::sampleT          baseline,
  output logic [delayCntWidth-1:0] preLen
);

  // Longest pre-acquisition the delay line supports
  localparam int maxPreLen = 2 ** (delayCntWidth - 1);

  logic access;
  logic addrOk;

  always_comb begin
    access = psel && penable;
    addrOk = (paddr == 4'h0) || (paddr == 4'h4) || (paddr == 4'h8);
  end

  // No wait states
  assign pready  = 1'b1;
  assign pslverr = access && !addrOk;

  // Read mux, signed fields are sign-extended
  always_comb begin
    case (paddr)
      4'h0:    prdata = 32'(threshold);
      4'h4:    prdata = 32'(baseline);
      4'h8:    prdata = 32'(preLen);
      default: prdata = '0;
    endcase
  end

  always_ff @(posedge sAxisAclk) begin
    if (!rstN) begin
      threshold <= '0;
      baseline  <= '0;
      preLen    <= delayCntWidth'(4);
    end else if (access && pwrite) begin
      case (paddr)
        4'h0: threshold <= pwdata[$bits(trigPkg::thresholdT)-1:0];
        4'h4: baseline  <= pwdata[$bits(trigPkg::sampleT)-1:0];
        4'h8: begin
          // Clip to the legal maximum
          if (pwdata > 32'(maxPreLen)) begin
            preLen <= delayCntWidth'(maxPreLen);
          end else begin
            preLen <= pwdata[delayCntWidth-1:0];
          end
        end
        default: ;
      endcase
    end
  end

  // Access phase always follows a selected setup phase
  penableNeedsPsel: assert property (
    @(posedge sAxisAclk) disable iff (!rstN) $rose(penable) |-> psel
  );

endmodule

`default_nettype wire

// File: design/hitDetector.sv
`timescale 1ns/100ps
`default_nettype none

module hitDetector #(
  parameter int postAcquiLen  = 38,
  parameter int delayCntWidth = 5
) (
  input  wire                      sAxisAclk,
  input  wire                      rstN,
  input  wire trigPkg::beatDataT   sAxisTdata,
  input  wire                      sAxisTvalid,
  input  wire                      advance,
  input  wire trigPkg::thresholdT  threshold,
  input  wire trigPkg::sampleT     baseline,
  output trigPkg::beatT            beatOut,
  output logic                     beatValid,
  output logic                     triggered
);

  localparam int laneWidth = $bits(trigPkg::beatDataT) / trigPkg::laneCount;
  localparam int postWidth = $clog2(postAcquiLen + 1);
  // Window count at least as wide as a delay count
  localparam int winWidth  = (postWidth > delayCntWidth) ? postWidth : delayCntWidth;

  logic                  accept;
  logic                  hitNow;
  logic                  hitReg;
  logic [winWidth-1:0]   winCnt;
  trigPkg::timeStampT    stampCnt;
  trigPkg::sampleT       sample;
  logic signed [13:0]    diff;

  assign accept = advance && sAxisTvalid;

  // Hit when any lane rises above baseline by more than threshold
  always_comb begin
    hitNow = 1'b0;
    sample = '0;
    diff   = '0;
    for (int i = 0; i < trigPkg::laneCount; i++) begin
      sample = sAxisTdata[i*laneWidth +: $bits(trigPkg::sampleT)];
      diff   = sample - baseline;
      if (diff > threshold) begin
        hitNow = 1'b1;
      end
    end
  end

  always_ff @(posedge sAxisAclk) begin
    if (!rstN) begin
      beatValid <= 1'b0;
      hitReg    <= 1'b0;
      winCnt    <= '0;
      stampCnt  <= '0;
    end else if (advance) begin
      beatValid <= sAxisTvalid;
      if (sAxisTvalid) begin
        hitReg   <= hitNow;
        stampCnt <= stampCnt + 1'b1;
        // Window opens after the registered hit beat
        if (hitReg) begin
          winCnt <= winWidth'(postAcquiLen);
        end else if (winCnt != '0) begin
          winCnt <= winCnt - 1'b1;
        end
      end
    end
  end

  always_ff @(posedge sAxisAclk) begin
    if (accept) begin
      beatOut.data  <= sAxisTdata;
      beatOut.stamp <= stampCnt;
    end
  end

  // Flag belongs to the beat held in beatOut
  assign triggered = hitReg || (winCnt != '0);

endmodule

`default_nettype wire

// File: design/preAcquiDelay.sv
`timescale 1ns/100ps
`default_nettype none

module preAcquiDelay #(
  parameter int delayCntWidth = 5
) (
  input  wire                      sAxisAclk,
  input  wire                      rstN,
  input  wire                      advance,
  input  wire [delayCntWidth-1:0]  preLen,
  input  wire trigPkg::beatT       beatIn,
  input  wire                      validIn,
  output trigPkg::beatT            beatOut,
  output logic                     validOut
);

  localparam int depth    = 2 ** delayCntWidth;
  localparam int maxDelay = 2 ** (delayCntWidth - 1);

  trigPkg::beatT            shiftReg [depth];
  logic [depth-1:0]         shiftValid;
  logic                     shiftEn;
  logic [delayCntWidth-1:0] tapIdx;

  // Shift only when a real beat moves in
  assign shiftEn = advance && validIn;
  assign tapIdx  = preLen - 1'b1;

  always_ff @(posedge sAxisAclk) begin
    if (shiftEn) begin
      shiftReg[0] <= beatIn;
      for (int i = 1; i < depth; i++) begin
        shiftReg[i] <= shiftReg[i-1];
      end
    end
  end

  // Marks entries filled since reset
  always_ff @(posedge sAxisAclk) begin
    if (!rstN) begin
      shiftValid <= '0;
    end else if (shiftEn) begin
      shiftValid <= {shiftValid[depth-2:0], 1'b1};
    end
  end

  // Entry preLen-1 holds the beat that entered preLen beats ago
  always_comb begin
    if (preLen == '0) begin
      beatOut  = beatIn;
      validOut = validIn;
    end else begin
      beatOut  = shiftReg[tapIdx];
      validOut = validIn && shiftValid[tapIdx];
    end
  end

  // Config block clips preLen to half the line
  preLenInRange: assert property (
    @(posedge sAxisAclk) disable iff (!rstN) validIn |-> (preLen <= maxDelay)
  );

endmodule

`default_nettype wire

// File: design/frameBuilder.sv
`timescale 1ns/100ps
`default_nettype none

module frameBuilder #(
  parameter int channelId      = 0,
  parameter int maxFrameLength = 200
) (
  input  wire                   sAxisAclk,
  input  wire                   rstN,
  input  wire trigPkg::beatT    beatIn,
  input  wire                   validIn,
  input  wire                   triggered,
  input  wire [7:0]             preLen,
  input  wire                   mTready,
  output logic                  advance,
  output trigPkg::frameWordT    mTdata,
  output logic                  mTvalid,
  output logic                  mTlast
);

  localparam int cntWidth = $clog2(maxFrameLength + 1);

  trigPkg::frameStateT state;
  logic [cntWidth-1:0] frameCount;
  trigPkg::timeStampT  lastStamp;
  trigPkg::frameWordT  headerWord;
  trigPkg::frameWordT  footerWord;
  logic                inFrame;
  logic                gated;
  logic                outFree;
  logic                startFrame;
  logic                endFrame;
  logic                takeBeat;

  always_comb begin
    inFrame    = (state == trigPkg::header) || (state == trigPkg::data);
    gated      = validIn && triggered;
    outFree    = !mTvalid || mTready;
    startFrame = !inFrame && gated;
    // Gate dropped or frame full, the held beat waits for the next frame
    endFrame   = inFrame && validIn && (!triggered || frameCount == cntWidth'(maxFrameLength));
    // Stall one cycle while a header or footer is loaded
    advance    = outFree && !startFrame && !endFrame;
    takeBeat   = advance && inFrame && validIn;
  end

  assign headerWord = {trigPkg::headerMarker, 8'(channelId), preLen, 8'h00, beatIn.stamp[31:0]};
  assign footerWord = {trigPkg::footerMarker, 8'(frameCount), lastStamp};

  always_ff @(posedge sAxisAclk) begin
    if (!rstN) begin
      state      <= trigPkg::idle;
      mTvalid    <= 1'b0;
      mTlast     <= 1'b0;
      frameCount <= '0;
    end else if (outFree) begin
      if (startFrame) begin
        mTvalid    <= 1'b1;
        mTlast     <= 1'b0;
        frameCount <= '0;
        state      <= trigPkg::header;
      end else if (endFrame) begin
        mTvalid <= 1'b1;
        mTlast  <= 1'b1;
        state   <= trigPkg::footer;
      end else if (takeBeat) begin
        mTvalid    <= 1'b1;
        mTlast     <= 1'b0;
        frameCount <= frameCount + 1'b1;
        state      <= trigPkg::data;
      end else begin
        mTvalid <= 1'b0;
        mTlast  <= 1'b0;
        // Footer has left, nothing gated behind it
        if (state == trigPkg::footer) begin
          state <= trigPkg::idle;
        end
      end
    end
  end

  // Output word and last captured stamp
  always_ff @(posedge sAxisAclk) begin
    if (outFree && startFrame) begin
      mTdata <= headerWord;
    end else if (outFree && endFrame) begin
      mTdata <= footerWord;
    end else if (takeBeat) begin
      mTdata    <= beatIn.data;
      lastStamp <= beatIn.stamp;
    end
  end

  // Word holds until the sink takes it
  outputStable: assert property (
    @(posedge sAxisAclk) disable iff (!rstN)
    mTvalid && !mTready |=> mTvalid && $stable(mTdata) && $stable(mTlast)
  );

endmodule

`default_nettype wire

// File: design/minimumTrigger.sv
`timescale 1ns/100ps
`default_nettype none

module minimumTrigger #(
  parameter int channelId      = 0,
  parameter int postAcquiLen   = 38,
  parameter int delayCntWidth  = 5,
  parameter int maxFrameLength = 200
) (
  input  wire                     sAxisAclk,
  input  wire                     rstN,
  // ADC beat stream
  input  wire trigPkg::beatDataT  sAxisTdata,
  input  wire                     sAxisTvalid,
  output logic                    sAxisTready,
  // Configuration
  input  wire [3:0]               paddr,
  input  wire                     psel,
  input  wire                     penable,
  input  wire                     pwrite,
  input  wire [31:0]              pwdata,
  output logic [31:0]             prdata,
  output logic                    pready,
  output logic                    pslverr,
  // Frame stream
  output trigPkg::frameWordT      mTdata,
  output logic                    mTvalid,
  input  wire                     mTready,
  output logic                    mTlast
);

  wire trigPkg::thresholdT       threshold;
  wire trigPkg::sampleT          baseline;
  wire [delayCntWidth-1:0]       preLen;
  wire trigPkg::beatT            detBeat;
  wire                           detValid;
  wire                           triggered;
  wire trigPkg::beatT            dlyBeat;
  wire                           dlyValid;

  trigConfigRegs #(
    .delayCntWidth(delayCntWidth)
  ) u_regs (
    .sAxisAclk(sAxisAclk),
    .rstN(rstN),
    .paddr(paddr),
    .psel(psel),
    .penable(penable),
    .pwrite(pwrite),
    .pwdata(pwdata),
    .prdata(prdata),
    .pready(pready),
    .pslverr(pslverr),
    .threshold(threshold),
    .baseline(baseline),
    .preLen(preLen)
  );

  // The frame builder's advance is the stream ready
  hitDetector #(
    .postAcquiLen(postAcquiLen),
    .delayCntWidth(delayCntWidth)
  ) u_hit (
    .sAxisAclk(sAxisAclk),
    .rstN(rstN),
    .sAxisTdata(sAxisTdata),
    .sAxisTvalid(sAxisTvalid),
    .advance(sAxisTready),
    .threshold(threshold),
    .baseline(baseline),
    .beatOut(detBeat),
    .beatValid(detValid),
    .triggered(triggered)
  );

  preAcquiDelay #(
    .delayCntWidth(delayCntWidth)
  ) u_delay (
    .sAxisAclk(sAxisAclk),
    .rstN(rstN),
    .advance(sAxisTready),
    .preLen(preLen),
    .beatIn(detBeat),
    .validIn(detValid),
    .beatOut(dlyBeat),
    .validOut(dlyValid)
  );

  frameBuilder #(
    .channelId(channelId),
    .maxFrameLength(maxFrameLength)
  ) u_frame (
    .sAxisAclk(sAxisAclk),
    .rstN(rstN),
    .beatIn(dlyBeat),
    .validIn(dlyValid),
    .triggered(triggered),
    .preLen(8'(preLen)),
    .mTready(mTready),
    .advance(sAxisTready),
    .mTdata(mTdata),
    .mTvalid(mTvalid),
    .mTlast(mTlast)
  );

endmodule

`default_nettype wire

// File: dv/minimumTriggerTb.sv
`timescale 1ns/100ps
`default_nettype none

module minimumTriggerTb;

  localparam int channelId      = 3;
  localparam int postAcquiLen   = 6;
  localparam int delayCntWidth  = 4;
  localparam int maxFrameLength = 20;
  localparam int preLenSet      = 5;
  localparam int quietLead      = 20;
  localparam int drainLen       = preLenSet + postAcquiLen + 4;
  localparam int burstLen       = 35;
  localparam int randomLen      = 120;
  // Seven quiet leads, seven drains with their tail, the burst and the random run
  localparam int totalBeats     = 7 * quietLead + 7 * (drainLen + maxFrameLength + 4)
                                  + burstLen + randomLen + 8;
  localparam int watchdogCycles = totalBeats * 4 + 500;

  typedef struct packed {
    logic               last;
    trigPkg::frameWordT data;
  } outWordT;

  logic               clk;
  logic               rstN;
  trigPkg::beatDataT  sAxisTdata;
  logic               sAxisTvalid;
  logic               sAxisTready;
  logic [3:0]         paddr;
  logic               psel;
  logic               penable;
  logic               pwrite;
  logic [31:0]        pwdata;
  logic [31:0]        prdata;
  logic               pready;
  logic               pslverr;
  trigPkg::frameWordT mTdata;
  logic               mTvalid;
  logic               mTready;
  logic               mTlast;

  // Stimulus and test bookkeeping
  logic [15:0]        lfsrState;
  logic               backPressure;
  string              testName;
  int                 errCount;
  int                 errAtStart;
  int                 testCount;
  int                 failedTests;
  int                 outFrames;
  int                 framesAtStart;
  int                 lastCount;
  int                 cfgThreshold;
  int                 cfgBaseline;
  int                 cfgPreLen;

  // Reference model state
  trigPkg::beatDataT  beatQ[$];
  bit                 hitQ[$];
  outWordT            expQ[$];
  outWordT            expHead;
  logic               expAvail;
  bit                 modelInFrame;
  int                 frameLen;
  int                 lastStamp;

  minimumTrigger #(
    .channelId(channelId),
    .postAcquiLen(postAcquiLen),
    .delayCntWidth(delayCntWidth),
    .maxFrameLength(maxFrameLength)
  ) u_dut (
    .sAxisAclk(clk),
    .rstN(rstN),
    .sAxisTdata(sAxisTdata),
    .sAxisTvalid(sAxisTvalid),
    .sAxisTready(sAxisTready),
    .paddr(paddr),
    .psel(psel),
    .penable(penable),
    .pwrite(pwrite),
    .pwdata(pwdata),
    .prdata(prdata),
    .pready(pready),
    .pslverr(pslverr),
    .mTdata(mTdata),
    .mTvalid(mTvalid),
    .mTready(mTready),
    .mTlast(mTlast)
  );

  initial begin
    clk = 1'b0;
    forever #(10) clk = ~clk;
  end

  // Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [31:0] takeBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 16'hB400) : (lfsrState >> 1);
      v = {v[30:0], lfsrState[0]};
    end
    return v;
  endfunction

  // Quiet lanes scatter within 64 counts of the baseline
  function automatic trigPkg::beatDataT makeBeat(input int hitLane, input int hitValue);
    trigPkg::beatDataT d;
    trigPkg::sampleT   s;
    d = '0;
    for (int i = 0; i < trigPkg::laneCount; i++) begin
      s = trigPkg::sampleT'(cfgBaseline + int'(takeBits(7)) - 64);
      if (i == hitLane) begin
        s = trigPkg::sampleT'(hitValue);
      end
      d[i*16 +: 16] = 16'(s);
    end
    return d;
  endfunction

  function automatic int strongHit();
    return cfgBaseline + cfgThreshold + 1 + int'(takeBits(6));
  endfunction

  function automatic bit laneHit(input trigPkg::beatDataT d);
    trigPkg::sampleT s;
    int              diff;
    bit              hit;
    hit = 1'b0;
    for (int i = 0; i < trigPkg::laneCount; i++) begin
      s    = trigPkg::sampleT'(d[i*16 +: 12]);
      diff = s - cfgBaseline;
      if (diff > cfgThreshold) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  function automatic void pushWord(input logic last, input trigPkg::frameWordT data);
    outWordT w;
    w.last = last;
    w.data = data;
    expQ.push_back(w);
  endfunction

  // Frame rules applied to beat n with its gate
  function automatic void builderStep(input int n, input bit gate);
    if (modelInFrame && (!gate || frameLen == maxFrameLength)) begin
      pushWord(1'b1, {8'h5A, 8'(frameLen), 48'(lastStamp)});
      modelInFrame = 1'b0;
    end
    if (!modelInFrame && gate) begin
      pushWord(1'b0, {8'hA5, 8'(channelId), 8'(cfgPreLen), 8'h00, 32'(n)});
      modelInFrame = 1'b1;
      frameLen     = 0;
    end
    if (modelInFrame) begin
      pushWord(1'b0, beatQ[n]);
      frameLen++;
      lastStamp = n;
    end
  endfunction

  // Beat k opens the window for itself and postAcquiLen beats after
  function automatic void modelAccept(input trigPkg::beatDataT d);
    int k;
    bit trig;
    k = beatQ.size();
    beatQ.push_back(d);
    hitQ.push_back(laneHit(d));
    trig = 1'b0;
    for (int j = k; j >= 0 && j >= k - postAcquiLen; j--) begin
      if (hitQ[j]) begin
        trig = 1'b1;
      end
    end
    if (k >= cfgPreLen) begin
      builderStep(k - cfgPreLen, trig);
    end
  endfunction

  always @(posedge clk) begin
    if (rstN) begin
      if (mTvalid && mTready) begin
        if (expQ.size() != 0) begin
          void'(expQ.pop_front());
        end
        if (mTlast) begin
          outFrames++;
          lastCount = int'(mTdata[55:48]);
        end
      end
      if (sAxisTvalid && sAxisTready) begin
        modelAccept(sAxisTdata);
      end
      expAvail = (expQ.size() != 0);
      expHead  = expAvail ? expQ[0] : '0;
    end
  end

  wordMatches: assert property (
    @(posedge clk) disable iff (!rstN)
    mTvalid && mTready && expAvail |-> {mTlast, mTdata} == expHead
  ) else begin
    errCount++;
    $display("FAIL %s: expected %h, actual %h", testName, $sampled(expHead),
             $sampled({mTlast, mTdata}));
  end

  wordExpected: assert property (
    @(posedge clk) disable iff (!rstN) mTvalid && mTready |-> expAvail
  ) else begin
    errCount++;
    $display("%s: DUT sent a word the model did not expect", testName);
  end

  task automatic driveReady();
    mTready = backPressure ? 1'(takeBits(1)) : 1'b1;
  endtask

  // Starts and ends on a falling edge
  task automatic sendBeat(input trigPkg::beatDataT d);
    logic took;
    sAxisTdata  = d;
    sAxisTvalid = 1'b1;
    do begin
      @(posedge clk);
      took = sAxisTready;
      @(negedge clk);
      driveReady();
    end while (!took);
  endtask

  task automatic sendQuiet(input int n);
    repeat (n) sendBeat(makeBeat(-1, 0));
  endtask

  task automatic sendHit(input int value);
    int lane;
    lane = int'(takeBits(2));
    sendBeat(makeBeat(lane, value));
  endtask

  task automatic drain();
    int guard;
    sendQuiet(drainLen);
    guard = 0;
    while (expQ.size() != 0 && guard < maxFrameLength + 4) begin
      sendQuiet(1);
      guard++;
    end
    assert (expQ.size() == 0) else begin
      errCount++;
      $display("%s: DUT stopped short, %0d frame words never arrived", testName, expQ.size());
    end
  endtask

  task automatic apbWrite(input logic [3:0] addr, input logic [31:0] data);
    paddr   = addr;
    pwdata  = data;
    pwrite  = 1'b1;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic checkRead(input logic [3:0] addr, input logic [31:0] expData,
                           input logic expErr);
    logic [31:0] data;
    logic        err;
    logic        rdy;
    paddr   = addr;
    pwrite  = 1'b0;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    @(posedge clk);
    data = prdata;
    err  = pslverr;
    rdy  = pready;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    assert (data == expData && err == expErr && rdy == 1'b1) else begin
      errCount++;
      $display("FAIL %s: addr %h expected %h err %0b ready 1, actual %h err %0b ready %0b",
               testName, addr, expData, expErr, data, err, rdy);
    end
  endtask

  // Frame count and length of the last frame seen on the output
  task automatic checkFrames(input int wantFrames, input int wantLen);
    assert (outFrames - framesAtStart == wantFrames) else begin
      errCount++;
      $display("FAIL %s: expected %0d frames, actual %0d", testName, wantFrames,
               outFrames - framesAtStart);
    end
    if (wantLen >= 0) begin
      assert (lastCount == wantLen) else begin
        errCount++;
        $display("FAIL %s: expected last frame length %0d, actual %0d", testName, wantLen,
                 lastCount);
      end
    end
  endtask

  task automatic startTest(input string name);
    testName      = name;
    errAtStart    = errCount;
    framesAtStart = outFrames;
  endtask

  task automatic finishTest();
    testCount++;
    if (errCount != errAtStart) begin
      failedTests++;
      $display("result %s: %0d errors", testName, errCount - errAtStart);
    end else begin
      $display("result %s: ok", testName);
    end
  endtask

  initial begin
    repeat (watchdogCycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run hung", watchdogCycles);
    $display("Test failed");
    $finish;
  end

  initial begin
    rstN         = 1'b0;
    sAxisTdata   = '0;
    sAxisTvalid  = 1'b0;
    paddr        = '0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    pwdata       = '0;
    mTready      = 1'b1;
    lfsrState    = 16'd57208;
    backPressure = 1'b0;
    errCount     = 0;
    testCount    = 0;
    failedTests  = 0;
    outFrames    = 0;
    lastCount    = 0;
    modelInFrame = 1'b0;
    frameLen     = 0;
    lastStamp    = 0;
    expAvail     = 1'b0;
    expHead      = '0;
    cfgThreshold = 0;
    cfgBaseline  = 0;
    cfgPreLen    = 4;
    repeat (10) @(negedge clk);
    rstN = 1'b1;

    startTest("apbRegs");
    apbWrite(4'h0, 32'd200);
    checkRead(4'h0, 32'd200, 1'b0);
    apbWrite(4'h4, 32'hFFFF_FFCE);
    checkRead(4'h4, 32'hFFFF_FFCE, 1'b0);
    // Reads back clipped to half the line depth
    apbWrite(4'h8, 32'd25);
    checkRead(4'h8, 32'(1 << (delayCntWidth - 1)), 1'b0);
    apbWrite(4'hC, 32'h1234);
    checkRead(4'hC, 32'h0, 1'b1);
    apbWrite(4'h4, 32'd100);
    apbWrite(4'h8, 32'(preLenSet));
    checkRead(4'h4, 32'd100, 1'b0);
    checkRead(4'h8, 32'(preLenSet), 1'b0);
    cfgThreshold = 200;
    cfgBaseline  = 100;
    cfgPreLen    = preLenSet;
    finishTest();

    // Frame spans the trigger window, shifted back by preLen beats
    startTest("singleHit");
    sendQuiet(quietLead);
    sendHit(strongHit());
    drain();
    checkFrames(1, postAcquiLen + 1);
    finishTest();

    startTest("closeHits");
    sendQuiet(quietLead);
    sendHit(strongHit());
    sendQuiet(2);
    sendHit(strongHit());
    drain();
    checkFrames(1, postAcquiLen + 4);
    finishTest();

    startTest("farHits");
    sendQuiet(quietLead);
    sendHit(strongHit());
    sendQuiet(quietLead - 1);
    sendHit(strongHit());
    drain();
    checkFrames(2, postAcquiLen + 1);
    finishTest();

    startTest("longBurst");
    sendQuiet(quietLead);
    repeat (burstLen) sendHit(strongHit());
    drain();
    checkFrames((burstLen + postAcquiLen + maxFrameLength - 1) / maxFrameLength,
                (burstLen + postAcquiLen - 1) % maxFrameLength + 1);
    finishTest();

    startTest("backPressure");
    backPressure = 1'b1;
    for (int i = 0; i < randomLen; i++) begin
      if (takeBits(4) == 0) begin
        sendHit(strongHit());
      end else begin
        sendQuiet(1);
      end
    end
    drain();
    backPressure = 1'b0;
    finishTest();

    startTest("thresholdEdge");
    sendQuiet(quietLead);
    sendHit(cfgBaseline + cfgThreshold);
    drain();
    checkFrames(0, -1);
    framesAtStart = outFrames;
    sendQuiet(quietLead);
    sendHit(cfgBaseline + cfgThreshold + 1);
    drain();
    checkFrames(1, postAcquiLen + 1);
    finishTest();

    $display("summary: %0d tests, %0d failed, %0d errors", testCount, failedTests, errCount);
    if (errCount == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: minimumTrigger.f
design/trigPkg.sv
design/trigConfigRegs.sv
design/hitDetector.sv
design/preAcquiDelay.sv
design/frameBuilder.sv
design/minimumTrigger.sv
dv/minimumTriggerTb.sv

// File: Bender.yml
package:
  name: minimumTrigger

sources:
  - design/trigPkg.sv
  - design/trigConfigRegs.sv
  - design/hitDetector.sv
  - design/preAcquiDelay.sv
  - design/frameBuilder.sv
  - design/minimumTrigger.sv
  - target: test
    files:
      - dv/minimumTriggerTb.sv
